//--- ro_stage.f
+incdir+include
rtl/ro_stage_pkg.sv
rtl/sync_fifo.sv
rtl/id_free_list.sv
rtl/burst_splitter.sv
rtl/thread_context.sv
rtl/line_unpacker.sv
rtl/ro_stage.sv
dv/ro_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ro_stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f ro_stage.f --top-module ro_stage_tb -o ro_stage_sim

out=$(./obj_dir/ro_stage_sim)
echo "$out"
echo "$out" | grep -q "^Everything OK$"

//--- dv/ro_stage_tb.sv
`timescale 1ns/100ps
`include "ro_stage_config.svh"

module ro_stage_tb import ro_stage_pkg::*; ();

   localparam int N_TASKS = 37;         // 1 + 2 + 12 + 12 + 10
   localparam int WORD_BOUND_NS = 16 * 4; // 16 cycles per word at most
   localparam int TIMEOUT_NS = N_TASKS * `RO_MAX_WORDS * WORD_BOUND_NS + 1000;
   // every thread slot busy and the task queue full
   localparam int MAX_OPEN = `RO_N_THREADS + 2**`RO_TFIFO_LOG_DEPTH;

   logic        clk = 1'b0;
   logic        rstn = 1'b0;
   logic        task_valid = 1'b0;
   logic        task_ready;
   task_tag_t   task_tag = '0;
   word_t       task_addr = '0;
   word_count_t task_len = '0;
   logic        ar_valid;
   logic        ar_ready = 1'b0;
   word_t       ar_addr;
   read_id_t    ar_id;
   logic        r_valid = 1'b0;
   logic        r_ready;
   read_id_t    r_id = '0;
   line_t       r_data = '0;
   logic        out_valid;
   logic        out_ready = 1'b1;
   task_tag_t   out_tag;
   word_t       out_data;
   word_count_t out_word_id;
   logic        out_last;
   logic        idle;

   integer      seed = 32'h859c;
   int          n_checks = 0;
   int          n_errors = 0;
   int          sub_tasks = 0;
   int          done_tasks = 0;
   int          r_sent = 0;     // responses put on the bus
   int          r_accepts = 0;  // responses taken by the DUT
   int          rsp_gap = 0;
   logic        stall_on = 1'b0;
   logic        saw_full = 1'b0;
   task_tag_t   next_tag = 16'h0001;

   // scoreboard, one entry per outstanding tag
   word_t       sb_addr [task_tag_t];
   int          sb_len [task_tag_t];
   int          sb_count [task_tag_t];
   logic [63:0] sb_seen [task_tag_t];
   word_t       exp_ar [$];      // expected request addresses, in task order
   read_id_t    pend_id [$];
   word_t       pend_base [$];
   logic        id_busy [2**`RO_LOG_IDS];

   logic        hold_chk = 1'b0;
   task_tag_t   h_tag;
   word_t       h_data;
   word_count_t h_id;
   logic        h_last;

   ro_stage i_ro_stage (.*);

   always #2 clk = ~clk;

   // reference memory contents, keyed by word address
   function automatic word_t mem_word(input word_t waddr);
      return (waddr * 32'h9e3779b1) ^ {waddr[15:0], waddr[31:16]};
   endfunction

   function automatic line_t line_at(input word_t base);
      line_t l;
      for (int i = 0; i < `RO_LINE_WORDS; i++) begin
         l[i*32 +: 32] = mem_word((base >> 2) + word_t'(i));
      end
      return l;
   endfunction

   task automatic check(input logic ok, input string msg);
      n_checks++;
      assert (ok) else begin
         n_errors++;
         $display("[FAIL] %0t: %s", $time, msg);
      end
   endtask

   // register an accepted task and the line requests it must produce
   task automatic add_task(input task_tag_t tag, input word_t addr, input word_count_t len);
      word_t a;
      int    rem;
      int    room;
      sb_addr[tag] = addr;
      sb_len[tag] = int'(len);
      sb_count[tag] = 0;
      sb_seen[tag] = '0;
      sub_tasks++;
      a = addr;
      rem = int'(len);
      room = `RO_LINE_WORDS - int'(a[5:2]);
      exp_ar.push_back(a);
      while (rem > room) begin
         rem -= room;
         a = {a[31:6] + 26'd1, 6'b0}; // next line base
         exp_ar.push_back(a);
         room = `RO_LINE_WORDS;
      end
   endtask

   task automatic take_word();
      int    idx;
      word_t exp;
      if (!sb_len.exists(out_tag)) begin
         check(1'b0, $sformatf("word for unknown tag %h", out_tag));
         return;
      end
      idx = int'(out_word_id);
      check(idx < sb_len[out_tag], $sformatf("word index %0d out of range for tag %h",
         idx, out_tag));
      check(((sb_seen[out_tag] >> idx) & 64'd1) == 0,
         $sformatf("word %0d of tag %h delivered twice", idx, out_tag));
      sb_seen[out_tag] = sb_seen[out_tag] | (64'd1 << idx);
      exp = mem_word((sb_addr[out_tag] >> 2) + word_t'(idx));
      check(out_data == exp, $sformatf("tag %h word %0d data %h, expected %h",
         out_tag, idx, out_data, exp));
      sb_count[out_tag]++;
      check(out_last == (sb_count[out_tag] == sb_len[out_tag]),
         $sformatf("out_last %b on word %0d of %0d for tag %h", out_last,
         sb_count[out_tag], sb_len[out_tag], out_tag));
      if (sb_count[out_tag] == sb_len[out_tag]) begin
         sb_addr.delete(out_tag);
         sb_len.delete(out_tag);
         sb_count.delete(out_tag);
         sb_seen.delete(out_tag);
         done_tasks++;
      end
   endtask

   // handshake monitor and checker
   always @(posedge clk) begin
      word_t exp_addr;
      if (!rstn) begin
         foreach (id_busy[i]) id_busy[i] = 1'b0;
         hold_chk = 1'b0;
      end else begin
         if (task_valid && task_ready) add_task(task_tag, task_addr, task_len);
         if (task_valid && !task_ready && (sub_tasks - done_tasks) >= MAX_OPEN) begin
            saw_full = 1'b1;
         end
         if (ar_valid && ar_ready) begin
            if (exp_ar.size() == 0) begin
               check(1'b0, $sformatf("read request %h with no line left to fetch", ar_addr));
            end else begin
               exp_addr = exp_ar.pop_front();
               check(ar_addr == exp_addr, $sformatf("read address %h, expected %h",
                  ar_addr, exp_addr));
            end
            check(!id_busy[ar_id], $sformatf("read id %0d reused while outstanding", ar_id));
            id_busy[ar_id] = 1'b1;
            pend_id.push_back(ar_id);
            pend_base.push_back({ar_addr[31:6], 6'b0});
         end
         if (r_valid && r_ready) begin
            id_busy[r_id] = 1'b0;
            r_accepts++;
         end
         if (hold_chk) begin
            check(out_valid && out_tag == h_tag && out_data == h_data &&
               out_word_id == h_id && out_last == h_last,
               $sformatf("output moved under back-pressure, tag %h word %0d", h_tag, h_id));
         end
         hold_chk = out_valid && !out_ready;
         h_tag = out_tag;
         h_data = out_data;
         h_id = out_word_id;
         h_last = out_last;
         if (out_valid) check(!idle, "idle is high while a word waits at the output");
         if (out_valid && out_ready) take_word();
      end
   end

   // memory model, answers pending reads in random order after a random gap
   always @(negedge clk) begin
      int pick;
      if (!rstn) begin
         ar_ready = 1'b0;
         r_valid = 1'b0;
      end else begin
         ar_ready = ($random(seed) & 3) != 0;
         if (r_valid && r_accepts == r_sent) r_valid = 1'b0;
         if (!r_valid) begin
            if (rsp_gap > 0) begin
               rsp_gap--;
            end else if (pend_id.size() > 0) begin
               pick = $unsigned($random(seed)) % pend_id.size();
               r_id = pend_id[pick];
               r_data = line_at(pend_base[pick]);
               pend_id.delete(pick);
               pend_base.delete(pick);
               r_valid = 1'b1;
               r_sent++;
               rsp_gap = $unsigned($random(seed)) % 4;
            end
         end
      end
   end

   always @(negedge clk) begin
      out_ready = stall_on ? (($random(seed) & 1) != 0) : 1'b1;
   end

   task automatic submit(input word_t addr, input int len);
      task_valid = 1'b1;
      task_tag = next_tag;
      task_addr = addr;
      task_len = word_count_t'(len);
      next_tag++;
      @(posedge clk);
      while (!task_ready) @(posedge clk);
      @(negedge clk);
      task_valid = 1'b0;
   endtask

   task automatic submit_random(input int min_len);
      word_t addr;
      int    len;
      addr = 32'h0001_0000 + ($random(seed) & 32'h0000_3ffc);
      len = min_len + $unsigned($random(seed)) % (`RO_MAX_WORDS - min_len + 1);
      submit(addr, len);
   endtask

   task automatic drain();
      while (done_tasks != sub_tasks) @(negedge clk);
      @(negedge clk);
      check(idle, "idle stays low after all words were accepted");
      check(exp_ar.size() == 0 && pend_id.size() == 0,
         $sformatf("%0d line requests missing, %0d reads unanswered",
         exp_ar.size(), pend_id.size()));
   endtask

   initial begin
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      check(!ar_valid && !out_valid && idle,
         $sformatf("after reset ar_valid %b out_valid %b idle %b", ar_valid, out_valid, idle));

      submit(32'h0000_1108, 5); // inside one line
      drain();

      submit(32'h0000_223c, 40); // 4 lines
      submit(32'h0000_2404, 64); // 5 lines
      drain();

      repeat (12) submit_random(1);
      drain();

      stall_on = 1'b1;
      repeat (12) submit_random(1);
      drain();

      // long tasks back to back, more than there are thread slots
      saw_full = 1'b0;
      repeat (10) submit_random(48);
      drain();
      check(saw_full, "task_ready never dropped while thread slots were busy");

      $display("checks %0d, errors %0d, tasks done %0d of %0d",
         n_checks, n_errors, done_tasks, sub_tasks);
      if (n_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: tasks still running after %0d ns, %0d of %0d done",
         TIMEOUT_NS, done_tasks, sub_tasks);
      $display("Something failed");
      $finish;
   end

endmodule

//--- rtl/ro_stage.sv
`timescale 1ns/100ps
`include "ro_stage_config.svh"

module ro_stage import ro_stage_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        task_valid,
   output logic        task_ready,
   input  task_tag_t   task_tag,
   input  word_t       task_addr,
   input  word_count_t task_len,
   output logic        ar_valid,
   input  logic        ar_ready,
   output word_t       ar_addr,
   output read_id_t    ar_id,
   input  logic        r_valid,
   output logic        r_ready,
   input  read_id_t    r_id,
   input  line_t       r_data,
   output logic        out_valid,
   input  logic        out_ready,
   output task_tag_t   out_tag,
   output word_t       out_data,
   output word_count_t out_word_id,
   output logic        out_last,
   output logic        idle
);

   task_req_t   task_wr, task_rd;
   logic        task_full, task_empty, task_take;
   rsp_beat_t   rsp_wr, rsp_rd;
   logic        rsp_full, rsp_empty, rsp_take;
   logic        thread_empty, thread_take, thread_give;
   thread_id_t  thread_next, thread_give_val;
   logic        id_empty, id_take, id_give;
   read_id_t    id_next, id_give_val;
   logic        mshr_wr_en;
   read_id_t    mshr_wr_id;
   ro_mshr_t    mshr_wr_data;
   logic        alloc_en, word_en;
   thread_id_t  alloc_thread, word_thread;
   task_tag_t   alloc_tag;
   word_count_t alloc_len;
   task_tag_t   ctx_tag [`RO_N_THREADS];
   logic        ctx_is_last [`RO_N_THREADS];

   assign task_wr = '{tag: task_tag, addr: task_addr, len: task_len};
   assign task_ready = !task_full;
   assign rsp_wr = '{id: r_id, data: r_data};
   assign r_ready = !rsp_full;

   sync_fifo #(.T(task_req_t), .LOG_DEPTH(`RO_TFIFO_LOG_DEPTH)) i_task_fifo (
      .clk(clk), .rstn(rstn),
      .wr_en(task_valid & task_ready), .wr_data(task_wr),
      .rd_en(task_take), .rd_data(task_rd),
      .full(task_full), .empty(task_empty)
   );

   sync_fifo #(.T(rsp_beat_t), .LOG_DEPTH(`RO_RFIFO_LOG_DEPTH)) i_rsp_fifo (
      .clk(clk), .rstn(rstn),
      .wr_en(r_valid & r_ready), .wr_data(rsp_wr),
      .rd_en(rsp_take), .rd_data(rsp_rd),
      .full(rsp_full), .empty(rsp_empty)
   );

   id_free_list #(.LOG_N($clog2(`RO_N_THREADS))) i_thread_list (
      .clk(clk), .rstn(rstn),
      .take(thread_take), .next_id(thread_next),
      .give(thread_give), .give_id(thread_give_val),
      .empty(thread_empty), .all_free(idle)
   );

   id_free_list #(.LOG_N(`RO_LOG_IDS)) i_rid_list (
      .clk(clk), .rstn(rstn),
      .take(id_take), .next_id(id_next),
      .give(id_give), .give_id(id_give_val),
      .empty(id_empty), .all_free()
   );

   burst_splitter i_splitter (
      .clk(clk), .rstn(rstn),
      .task_avail(!task_empty), .task_in(task_rd), .task_take(task_take),
      .thread_free(!thread_empty), .thread_next(thread_next), .thread_take(thread_take),
      .id_free(!id_empty), .id_next(id_next), .id_take(id_take),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_id(ar_id),
      .mshr_wr_en(mshr_wr_en), .mshr_wr_id(mshr_wr_id), .mshr_wr_data(mshr_wr_data),
      .alloc_en(alloc_en), .alloc_thread(alloc_thread),
      .alloc_tag(alloc_tag), .alloc_len(alloc_len)
   );

   for (genvar g = 0; g < `RO_N_THREADS; g++) begin : g_ctx
      thread_context #(.THREAD_IDX(g)) i_ctx (
         .clk(clk), .rstn(rstn),
         .alloc_en(alloc_en), .alloc_thread(alloc_thread),
         .alloc_tag(alloc_tag), .alloc_len(alloc_len),
         .word_en(word_en), .word_thread(word_thread),
         .tag(ctx_tag[g]), .is_last(ctx_is_last[g])
      );
   end

   line_unpacker i_unpacker (
      .clk(clk), .rstn(rstn),
      .rsp_avail(!rsp_empty), .rsp_in(rsp_rd), .rsp_take(rsp_take),
      .mshr_wr_en(mshr_wr_en), .mshr_wr_id(mshr_wr_id), .mshr_wr_data(mshr_wr_data),
      .ctx_tag(ctx_tag), .ctx_is_last(ctx_is_last),
      .id_give(id_give), .id_give_val(id_give_val),
      .thread_give(thread_give), .thread_give_val(thread_give_val),
      .word_en(word_en), .word_thread(word_thread),
      .out_valid(out_valid), .out_ready(out_ready), .out_tag(out_tag),
      .out_data(out_data), .out_word_id(out_word_id), .out_last(out_last)
   );

endmodule

//--- rtl/line_unpacker.sv
`timescale 1ns/100ps
`include "ro_stage_config.svh"

module line_unpacker import ro_stage_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        rsp_avail,
   input  rsp_beat_t   rsp_in,
   output logic        rsp_take,
   input  logic        mshr_wr_en,
   input  read_id_t    mshr_wr_id,
   input  ro_mshr_t    mshr_wr_data,
   input  task_tag_t   ctx_tag [`RO_N_THREADS],
   input  logic        ctx_is_last [`RO_N_THREADS],
   output logic        id_give,
   output read_id_t    id_give_val,
   output logic        thread_give,
   output thread_id_t  thread_give_val,
   output logic        word_en,
   output thread_id_t  word_thread,
   output logic        out_valid,
   input  logic        out_ready,
   output task_tag_t   out_tag,
   output word_t       out_data,
   output word_count_t out_word_id,
   output logic        out_last
);

   localparam int LW_BITS = $clog2(`RO_LINE_WORDS);

   ro_mshr_t mshr_tab [2**`RO_LOG_IDS];
   ro_mshr_t rsp_mshr;

   logic                      reg_valid;
   line_t                     reg_line;
   logic [`RO_LINE_WORDS-1:0] reg_mask;
   thread_id_t                reg_thread;

   logic [LW_BITS-1:0]        sel;
   logic [`RO_LINE_WORDS-1:0] next_mask;
   logic                      fire;

   always_ff @(posedge clk) begin
      if (mshr_wr_en) begin
         mshr_tab[mshr_wr_id] <= mshr_wr_data;
      end
   end

   assign rsp_mshr = mshr_tab[rsp_in.id];

   // lowest valid word goes out first
   always_comb begin
      sel = '0;
      for (int i = `RO_LINE_WORDS-1; i >= 0; i--) begin
         if (reg_mask[i]) sel = LW_BITS'(i);
      end
   end

   assign next_mask = reg_mask & ~(`RO_LINE_WORDS'(1) << sel);
   assign fire = out_valid & out_ready;
   assign rsp_take = rsp_avail & (!reg_valid | (fire & (next_mask == '0)));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_valid <= 1'b0;
      end else if (rsp_take) begin
         reg_valid <= 1'b1;
      end else if (fire && (next_mask == '0)) begin
         reg_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_take) begin
         reg_line <= rsp_in.data;
         reg_mask <= rsp_mshr.valid_words;
         reg_thread <= rsp_mshr.thread;
         out_word_id <= rsp_mshr.start_word;
      end else if (fire) begin
         reg_mask <= next_mask;
         out_word_id <= out_word_id + 1'b1;
      end
   end

   assign out_valid = reg_valid; // a loaded line always has at least one word
   assign out_data = reg_line[sel*32 +: 32];
   assign out_tag = ctx_tag[reg_thread];
   assign out_last = ctx_is_last[reg_thread];

   assign id_give = rsp_take; // record already copied out
   assign id_give_val = rsp_in.id;
   assign thread_give = fire & out_last;
   assign thread_give_val = reg_thread;
   assign word_en = fire;
   assign word_thread = reg_thread;

endmodule

//--- rtl/thread_context.sv
`timescale 1ns/100ps

module thread_context import ro_stage_pkg::*; #(
   parameter int THREAD_IDX = 0
) (
   input  logic        clk,
   input  logic        rstn,
   input  logic        alloc_en,
   input  thread_id_t  alloc_thread,
   input  task_tag_t   alloc_tag,
   input  word_count_t alloc_len,
   input  logic        word_en,
   input  thread_id_t  word_thread,
   output task_tag_t   tag,
   output logic        is_last
);

   word_count_t remaining;
   logic        hit_alloc;
   logic        hit_word;

   assign hit_alloc = alloc_en && (alloc_thread == thread_id_t'(THREAD_IDX));
   assign hit_word = word_en && (word_thread == thread_id_t'(THREAD_IDX));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         remaining <= '0;
      end else if (hit_alloc) begin
         remaining <= alloc_len;
      end else if (hit_word) begin
         remaining <= remaining - 1'b1;
      end
   end

   // tag only matters while the slot is live
   always_ff @(posedge clk) begin
      if (hit_alloc) begin
         tag <= alloc_tag;
      end
   end

   assign is_last = (remaining == word_count_t'(1));

endmodule

//--- rtl/burst_splitter.sv
`timescale 1ns/100ps
`include "ro_stage_config.svh"

module burst_splitter import ro_stage_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        task_avail,
   input  task_req_t   task_in,
   output logic        task_take,
   input  logic        thread_free,
   input  thread_id_t  thread_next,
   output logic        thread_take,
   input  logic        id_free,
   input  read_id_t    id_next,
   output logic        id_take,
   output logic        ar_valid,
   input  logic        ar_ready,
   output word_t       ar_addr,
   output read_id_t    ar_id,
   output logic        mshr_wr_en,
   output read_id_t    mshr_wr_id,
   output ro_mshr_t    mshr_wr_data,
   output logic        alloc_en,
   output thread_id_t  alloc_thread,
   output task_tag_t   alloc_tag,
   output word_count_t alloc_len
);

   localparam int LW_BITS = $clog2(`RO_LINE_WORDS);

   logic        busy;
   word_t       cur_addr;
   word_count_t rem_words;
   word_count_t start_word;
   thread_id_t  cur_thread;

   word_count_t line_off;
   word_count_t room;
   word_count_t n_words;
   logic        last_req;
   logic        ar_fire;
   logic        accept;
   word_t       next_base;
   logic [`RO_LINE_WORDS-1:0] mask;

   assign line_off = word_count_t'(cur_addr[LW_BITS+1:2]);
   assign room = word_count_t'(`RO_LINE_WORDS) - line_off; // words left in this line
   assign last_req = (rem_words <= room);
   assign n_words = last_req ? rem_words : room;
   assign next_base = {cur_addr[31:LW_BITS+2] + 1'b1, {(LW_BITS+2){1'b0}}};

   always_comb begin
      for (int i = 0; i < `RO_LINE_WORDS; i++) begin
         mask[i] = (i >= int'(line_off)) && (i < int'(line_off) + int'(n_words));
      end
   end

   assign ar_valid = busy & id_free;
   assign ar_fire = ar_valid & ar_ready;
   // next task may load in the cycle the current burst ends
   assign accept = task_avail & thread_free & (!busy | (ar_fire & last_req));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (ar_fire & last_req) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr <= task_in.addr;
         rem_words <= task_in.len;
         start_word <= '0;
         cur_thread <= thread_next;
      end else if (ar_fire) begin
         cur_addr <= next_base;
         rem_words <= rem_words - n_words;
         start_word <= start_word + n_words;
      end
   end

   assign task_take = accept;
   assign thread_take = accept;
   assign alloc_en = accept;
   assign alloc_thread = thread_next;
   assign alloc_tag = task_in.tag;
   assign alloc_len = task_in.len;

   assign ar_addr = cur_addr;
   assign ar_id = id_next;
   assign id_take = ar_fire;

   assign mshr_wr_en = ar_fire;
   assign mshr_wr_id = id_next;
   assign mshr_wr_data = '{thread: cur_thread, valid_words: mask, start_word: start_word};

endmodule

//--- rtl/id_free_list.sv
`timescale 1ns/100ps

module id_free_list #(
   parameter int LOG_N = 5
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             take,
   output logic [LOG_N-1:0] next_id,
   input  logic             give,
   input  logic [LOG_N-1:0] give_id,
   output logic             empty,
   output logic             all_free
);

   localparam int N = 2**LOG_N;

   logic [LOG_N-1:0] ring [N];
   logic [LOG_N:0]   rd_ptr;
   logic [LOG_N:0]   wr_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= {1'b1, {LOG_N{1'b0}}}; // every id present
         for (int i = 0; i < N; i++) begin
            ring[i] <= LOG_N'(i);
         end
      end else begin
         if (take) rd_ptr <= rd_ptr + 1'b1;
         if (give) begin
            ring[wr_ptr[LOG_N-1:0]] <= give_id;
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   assign next_id = ring[rd_ptr[LOG_N-1:0]];
   assign empty = (rd_ptr == wr_ptr);
   assign all_free = ((rd_ptr ^ wr_ptr) == {1'b1, {LOG_N{1'b0}}});

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
   parameter type T = logic,
   parameter int LOG_DEPTH = 2
) (
   input  logic clk,
   input  logic rstn,
   input  logic wr_en,
   input  T     wr_data,
   input  logic rd_en,
   output T     rd_data,
   output logic full,
   output logic empty
);

   localparam int DEPTH = 2**LOG_DEPTH;

   T mem [DEPTH];

   // extra msb tells full from empty
   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]]; // head is visible without a pop
   assign empty = (wr_ptr == rd_ptr);
   assign full = ((wr_ptr ^ rd_ptr) == {1'b1, {LOG_DEPTH{1'b0}}});

endmodule

//--- rtl/ro_stage_pkg.sv
`include "ro_stage_config.svh"

package ro_stage_pkg;

   typedef logic [31:0] word_t;
   typedef logic [`RO_LINE_WORDS*32-1:0] line_t;
   typedef logic [15:0] task_tag_t;
   // wide enough to hold RO_MAX_WORDS plus margin for index arithmetic
   typedef logic [$clog2(`RO_MAX_WORDS)+1:0] word_count_t;
   typedef logic [$clog2(`RO_N_THREADS)-1:0] thread_id_t;
   typedef logic [`RO_LOG_IDS-1:0] read_id_t;

   typedef struct packed {
      task_tag_t   tag;
      word_t       addr; // word aligned
      word_count_t len;  // 1 .. RO_MAX_WORDS
   } task_req_t;

   typedef struct packed {
      read_id_t id;
      line_t    data;
   } rsp_beat_t;

   typedef struct packed {
      thread_id_t               thread;
      logic [`RO_LINE_WORDS-1:0] valid_words;
      word_count_t              start_word; // task index of lowest valid word
   } ro_mshr_t;

endpackage

//--- include/ro_stage_config.svh
`ifndef RO_STAGE_CONFIG_SVH
`define RO_STAGE_CONFIG_SVH

// 32-bit words in one 64-byte cache line
`define RO_LINE_WORDS 16

// concurrent task slots
`define RO_N_THREADS 4

// read id width, 32 ids outstanding at most
`define RO_LOG_IDS 5

`define RO_RFIFO_LOG_DEPTH 2 // response queue, 4 lines
`define RO_TFIFO_LOG_DEPTH 1 // task queue, 2 tasks

// longest task in words
`define RO_MAX_WORDS 64

`endif
